// ==== verilog/dtm_defs.svh ====
// Constants shared by the JTAG debug transport module
// Sizes of the IR and DMI fields, the IDCODE value and the DTMCS fields
// Include wherever a width or a DTMCS field is needed
`ifndef DTM_DEFS_SVH
`define DTM_DEFS_SVH

// ------------------------------------------------------------
// Scan widths
// ------------------------------------------------------------
`define DTM_IR_WIDTH        5               // Instruction register length
`define DMI_ABITS           7               // DMI address bits
`define DMI_DATA_WIDTH      32              // DMI data bits
`define DMI_WIDTH           41              // addr + data + op

// Fixed identification, bit 0 is always one
`define DTM_IDCODE          32'h0DB6_1A4D

// ------------------------------------------------------------
// DTMCS fields
// ------------------------------------------------------------
`define DTMCS_IDLE          3'd5            // Run-Test-Idle hint
`define DTMCS_ABITS         6'd7            // Must match DMI_ABITS
`define DTMCS_VERSION       4'd1            // Debug spec 0.13

// Writing one here clears sticky dmistat
`define DTMCS_DMIRESET_BIT  16

`endif

// ==== verilog/dtm_pkg.sv ====
// Types of the JTAG debug transport module
// TAP states, IR codes, DMI op and status, and the structs between blocks
// Compile before any DTM module; the testbench imports it too
`include "dtm_defs.svh"

package dtm_pkg;

    // TAP states in the usual 1149.1 encoding
    typedef enum logic [3:0] {
        TAP_EXIT2_DR   = 4'h0,
        TAP_EXIT1_DR   = 4'h1,
        TAP_SHIFT_DR   = 4'h2,
        TAP_PAUSE_DR   = 4'h3,
        TAP_SELECT_IR  = 4'h4,
        TAP_UPDATE_DR  = 4'h5,
        TAP_CAPTURE_DR = 4'h6,
        TAP_SELECT_DR  = 4'h7,
        TAP_EXIT2_IR   = 4'h8,
        TAP_EXIT1_IR   = 4'h9,
        TAP_SHIFT_IR   = 4'hA,
        TAP_PAUSE_IR   = 4'hB,
        TAP_RUN_IDLE   = 4'hC,
        TAP_UPDATE_IR  = 4'hD,
        TAP_CAPTURE_IR = 4'hE,
        TAP_RESET      = 4'hF
    } tap_state_e;

    // IR codes, anything else acts as BYPASS
    typedef enum logic [`DTM_IR_WIDTH-1:0] {
        IR_IDCODE = 5'h01,
        IR_DTMCS  = 5'h10,
        IR_DMI    = 5'h11,
        IR_BYPASS = 5'h1F
    } jtag_ir_e;

    typedef enum logic [1:0] {DMI_NOP, DMI_READ, DMI_WRITE, DMI_RSVD} dmi_op_e;

    // Sticky DMI status, 1 is not used
    typedef enum logic [1:0] {STAT_OK = 2'd0, STAT_FAILED = 2'd2, STAT_BUSY = 2'd3} dmi_stat_e;

    // Bus master FSM
    typedef enum logic [1:0] {BUS_IDLE, BUS_REQ, BUS_WAIT} bus_state_e;

    typedef struct packed {
        jtag_ir_e ir;           // Active instruction
        logic     capture_dr;
        logic     shift_dr;
        logic     update_dr;
        logic     shift_ir;
        logic     ir_tdo;       // IR shift LSB
    } tap_ctl_t;

    // Same layout as the DMI scan, op in the LSBs
    typedef struct packed {
        logic [`DMI_ABITS-1:0]      addr;
        logic [`DMI_DATA_WIDTH-1:0] data;
        dmi_op_e                    op;
    } dmi_req_t;

    typedef struct packed {
        logic [`DMI_DATA_WIDTH-1:0] data;
        logic                       err;
    } dmi_rsp_t;

endpackage

// ==== verilog/tap_controller.sv ====
// JTAG TAP controller of the debug transport module
// Runs the 16-state TAP machine on TCK and holds the instruction register
// Hands the data registers a small control struct per cycle
`timescale 1ns/100ps
`include "dtm_defs.svh"

module tap_controller
(
    input  logic              TCK,      // JTAG clock
    input  logic              RES_DBG,  // Async reset, active high
    input  logic              tms,
    input  logic              tdi,
    output dtm_pkg::tap_ctl_t ctl       // To data registers
);
    import dtm_pkg::*;

    tap_state_e               state;
    tap_state_e               state_nxt;
    logic [`DTM_IR_WIDTH-1:0] ir_shift;     // IR scan chain
    jtag_ir_e                 ir;           // Active instruction

    // ------------------------------------------------------------
    // TAP state machine
    // ------------------------------------------------------------
    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
            state <= TAP_RESET;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        case (state)
            TAP_RESET      : state_nxt = tms ? TAP_RESET     : TAP_RUN_IDLE;
            TAP_RUN_IDLE   : state_nxt = tms ? TAP_SELECT_DR : TAP_RUN_IDLE;
            // DR column
            TAP_SELECT_DR  : state_nxt = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR : state_nxt = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR   : state_nxt = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR   : state_nxt = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR   : state_nxt = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR   : state_nxt = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR  : state_nxt = tms ? TAP_SELECT_DR : TAP_RUN_IDLE;
            // IR column
            TAP_SELECT_IR  : state_nxt = tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR : state_nxt = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR   : state_nxt = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR   : state_nxt = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR   : state_nxt = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR   : state_nxt = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR  : state_nxt = tms ? TAP_SELECT_DR : TAP_RUN_IDLE;
            default        : state_nxt = TAP_RESET;
        endcase
    end

    // ------------------------------------------------------------
    // Instruction register
    // ------------------------------------------------------------
    // Scan chain, captures the mandatory 01 pattern
    always_ff @(posedge TCK)
    begin
        if (state == TAP_CAPTURE_IR)
            ir_shift <= `DTM_IR_WIDTH'(1);
        else if (state == TAP_SHIFT_IR)
            ir_shift <= {tdi, ir_shift[`DTM_IR_WIDTH-1:1]};  // LSB out first
    end

    // Active IR, back to IDCODE whenever the TAP sits in reset
    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
            ir <= IR_IDCODE;
        else if (state == TAP_RESET)
            ir <= IR_IDCODE;
        else if (state == TAP_UPDATE_IR)
            ir <= jtag_ir_e'(ir_shift);     // Unknown codes kept, decoded as BYPASS
    end

    // Decoded controls for the data registers
    always_comb
    begin
        ctl.ir         = ir;
        ctl.capture_dr = (state == TAP_CAPTURE_DR);
        ctl.shift_dr   = (state == TAP_SHIFT_DR);
        ctl.update_dr  = (state == TAP_UPDATE_DR);
        ctl.shift_ir   = (state == TAP_SHIFT_IR);
        ctl.ir_tdo     = ir_shift[0];
    end

endmodule

// ==== verilog/dtm_data_regs.sv ====
// Data registers of the JTAG debug transport module
// BYPASS, IDCODE, DTMCS and DMI scan chains selected by the IR
// Issues DMI commands to the bus master and keeps the sticky DMI status
// Drives TDO and its enable on the falling TCK edge
`timescale 1ns/100ps
`include "dtm_defs.svh"

module dtm_data_regs
(
    input  logic              TCK,
    input  logic              RES_DBG,
    input  logic              tdi,
    input  dtm_pkg::tap_ctl_t ctl,          // From TAP controller
    output dtm_pkg::dmi_req_t cmd,          // Command to bus master
    output logic              cmd_valid,
    input  logic              cmd_ready,
    input  dtm_pkg::dmi_rsp_t rsp,          // Response from bus master
    input  logic              rsp_valid,
    output logic              tdo,
    output logic              tdo_e
);
    import dtm_pkg::*;

    logic                       sel_idcode;
    logic                       sel_dtmcs;
    logic                       sel_dmi;
    logic                       sel_bypass;
    logic                       bypass_shift;
    logic [31:0]                idcode_shift;
    logic [31:0]                dtmcs_shift;
    logic [31:0]                dtmcs_capture;
    logic [`DMI_WIDTH-1:0]      dmi_shift;
    dmi_req_t                   dmi_capture;
    dmi_stat_e                  status;         // Sticky until dmireset
    logic                       in_progress;    // Issued, no response yet
    logic [`DMI_ABITS-1:0]      addr_q;         // Address of last command
    logic [`DMI_DATA_WIDTH-1:0] rdata_q;        // Data of last response
    logic                       dmi_update;
    logic                       dmireset;
    logic                       busy_hit;
    logic                       dr_tdo;

    // Register select, unknown IR codes fall to BYPASS
    assign sel_idcode = (ctl.ir == IR_IDCODE);
    assign sel_dtmcs  = (ctl.ir == IR_DTMCS);
    assign sel_dmi    = (ctl.ir == IR_DMI);
    assign sel_bypass = !(sel_idcode || sel_dtmcs || sel_dmi);

    // ------------------------------------------------------------
    // BYPASS and IDCODE
    // ------------------------------------------------------------
    always_ff @(posedge TCK)
    begin
        if (sel_bypass && ctl.capture_dr)
            bypass_shift <= 1'b0;
        else if (sel_bypass && ctl.shift_dr)
            bypass_shift <= tdi;                    // One bit of delay
    end

    always_ff @(posedge TCK)
    begin
        if (sel_idcode && ctl.capture_dr)
            idcode_shift <= `DTM_IDCODE;
        else if (sel_idcode && ctl.shift_dr)
            idcode_shift <= {tdi, idcode_shift[31:1]};
    end

    // ------------------------------------------------------------
    // DTMCS
    // ------------------------------------------------------------
    // dmihardreset, dmireset and bit 15 all read as zero
    assign dtmcs_capture = {17'd0, `DTMCS_IDLE, status, `DTMCS_ABITS, `DTMCS_VERSION};

    always_ff @(posedge TCK)
    begin
        if (sel_dtmcs && ctl.capture_dr)
            dtmcs_shift <= dtmcs_capture;
        else if (sel_dtmcs && ctl.shift_dr)
            dtmcs_shift <= {tdi, dtmcs_shift[31:1]};
    end

    assign dmireset = ctl.update_dr && sel_dtmcs && dtmcs_shift[`DTMCS_DMIRESET_BIT];

    // ------------------------------------------------------------
    // DMI scan and command issue
    // ------------------------------------------------------------
    assign cmd        = dmi_req_t'(dmi_shift);
    assign dmi_update = ctl.update_dr && sel_dmi;

    // One command at a time, only with a clean status
    assign cmd_valid = dmi_update && (cmd.op != DMI_NOP)
                       && (status == STAT_OK) && !in_progress;

    // Update or capture that comes too early
    assign busy_hit = (dmi_update && in_progress)
                      || (ctl.capture_dr && sel_dmi && in_progress);

    // Capture value
    always_comb
    begin
        if (status != STAT_OK)
            dmi_capture = '{addr: '0, data: '0, op: dmi_op_e'(status)};
        else if (in_progress)
            dmi_capture = '{addr: '0, data: '0, op: dmi_op_e'(STAT_BUSY)};
        else
            dmi_capture = '{addr: addr_q, data: rdata_q, op: DMI_NOP};
    end

    always_ff @(posedge TCK)
    begin
        if (sel_dmi && ctl.capture_dr)
            dmi_shift <= dmi_capture;
        else if (sel_dmi && ctl.shift_dr)
            dmi_shift <= {tdi, dmi_shift[`DMI_WIDTH-1:1]};
    end

    // Command tracking and last response
    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
        begin
            in_progress <= 1'b0;
            addr_q      <= '0;
            rdata_q     <= '0;
        end
        else if (cmd_valid && cmd_ready)
        begin
            in_progress <= 1'b1;
            addr_q      <= cmd.addr;
        end
        else if (rsp_valid)
        begin
            in_progress <= 1'b0;
            rdata_q     <= rsp.data;            // Write data for writes
        end
    end

    // Sticky status, first error wins
    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
            status <= STAT_OK;
        else if (dmireset)
            status <= STAT_OK;
        else if (status == STAT_OK)
        begin
            if (busy_hit)
                status <= STAT_BUSY;
            else if (rsp_valid && rsp.err)
                status <= STAT_FAILED;
        end
    end

    // ------------------------------------------------------------
    // TDO
    // ------------------------------------------------------------
    always_comb
    begin
        if (sel_idcode)
            dr_tdo = idcode_shift[0];
        else if (sel_dtmcs)
            dr_tdo = dtmcs_shift[0];
        else if (sel_dmi)
            dr_tdo = dmi_shift[0];
        else
            dr_tdo = bypass_shift;
    end

    // Falling edge so the probe samples a settled bit on the next rise
    always_ff @(negedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
        begin
            tdo   <= 1'b1;
            tdo_e <= 1'b0;
        end
        else if (ctl.shift_ir)
        begin
            tdo   <= ctl.ir_tdo;
            tdo_e <= 1'b1;
        end
        else if (ctl.shift_dr)
        begin
            tdo   <= dr_tdo;
            tdo_e <= 1'b1;
        end
        else
        begin
            tdo   <= 1'b1;                  // Idle high
            tdo_e <= 1'b0;
        end
    end

endmodule

// ==== verilog/dmi_bus_master.sv ====
// Debug-module bus master of the JTAG DTM
// Takes one command from the data registers and presents it on the DM bus
// Waits for the response and hands it back as a one-cycle pulse
`timescale 1ns/100ps

module dmi_bus_master
(
    input  logic              TCK,
    input  logic              RES_DBG,
    input  dtm_pkg::dmi_req_t cmd,              // From data registers
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output dtm_pkg::dmi_rsp_t rsp,              // Back to data registers
    output logic              rsp_valid,
    output dtm_pkg::dmi_req_t dm_req,           // DM request bus
    output logic              dm_req_valid,
    input  logic              dm_req_ready,
    input  dtm_pkg::dmi_rsp_t dm_rsp,           // DM response
    input  logic              dm_rsp_valid
);
    import dtm_pkg::*;

    bus_state_e state;
    dmi_req_t   cmd_q;      // Held for the whole access
    logic       cmd_fire;
    logic       req_fire;

    assign cmd_ready = (state == BUS_IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign req_fire  = dm_req_valid && dm_req_ready;

    // ------------------------------------------------------------
    // Access FSM
    // ------------------------------------------------------------
    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
        begin
            state        <= BUS_IDLE;
            dm_req_valid <= 1'b0;
        end
        else
        begin
            case (state)
                BUS_IDLE :
                    if (cmd_fire)
                        state <= BUS_REQ;
                BUS_REQ :
                    if (req_fire)
                    begin
                        dm_req_valid <= 1'b0;
                        state        <= BUS_WAIT;
                    end
                    else
                        dm_req_valid <= 1'b1;   // Raised one cycle after load
                BUS_WAIT :
                    if (dm_rsp_valid)
                        state <= BUS_IDLE;
                default :
                    state <= BUS_IDLE;
            endcase
        end
    end

    // Command payload
    always_ff @(posedge TCK)
    begin
        if (cmd_fire)
            cmd_q <= cmd;
    end

    assign dm_req = cmd_q;              // Stable through REQ

    // Response path, write returns its own data
    assign rsp_valid = (state == BUS_WAIT) && dm_rsp_valid;
    assign rsp.data  = (cmd_q.op == DMI_WRITE) ? cmd_q.data : dm_rsp.data;
    assign rsp.err   = dm_rsp.err;

endmodule

// ==== verilog/dtm_jtag_top.sv ====
// Top level of the JTAG debug transport module
// Connects the TAP controller, the data registers and the DM bus master
// JTAG pins on one side, the debug-module request and response on the other
`timescale 1ns/100ps

module dtm_jtag_top
(
    input  logic              TCK,              // JTAG clock
    input  logic              RES_DBG,          // Async reset, active high
    input  logic              tms,
    input  logic              tdi,
    output logic              tdo,
    output logic              tdo_e,            // Pad output enable
    output dtm_pkg::dmi_req_t dm_req,
    output logic              dm_req_valid,
    input  logic              dm_req_ready,
    input  dtm_pkg::dmi_rsp_t dm_rsp,
    input  logic              dm_rsp_valid
);
    import dtm_pkg::*;

    tap_ctl_t ctl;
    dmi_req_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    dmi_rsp_t rsp;
    logic     rsp_valid;

    // ------------------------------------------------------------
    // TAP, data registers, bus master
    // ------------------------------------------------------------
    tap_controller u_tap
    (
        .TCK     (TCK),
        .RES_DBG (RES_DBG),
        .tms     (tms),
        .tdi     (tdi),
        .ctl     (ctl)
    );

    dtm_data_regs u_regs
    (
        .TCK       (TCK),
        .RES_DBG   (RES_DBG),
        .tdi       (tdi),
        .ctl       (ctl),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .tdo       (tdo),
        .tdo_e     (tdo_e)
    );

    dmi_bus_master u_master
    (
        .TCK          (TCK),
        .RES_DBG      (RES_DBG),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .dm_req       (dm_req),
        .dm_req_valid (dm_req_valid),
        .dm_req_ready (dm_req_ready),
        .dm_rsp       (dm_rsp),
        .dm_rsp_valid (dm_rsp_valid)
    );

endmodule

// ==== tests/dtm_jtag_sva.sv ====
// Concurrent checks on the debug-module request bus and the TDO enable
// Attached to the DTM top level by the bind at the bottom
`timescale 1ns/100ps

module dtm_jtag_sva
(
    input logic              TCK,
    input logic              RES_DBG,
    input dtm_pkg::tap_ctl_t ctl,               // TAP decode inside the top
    input logic              tdo_e,
    input dtm_pkg::dmi_req_t dm_req,
    input logic              dm_req_valid,
    input logic              dm_req_ready,
    input logic              dm_rsp_valid
);

    logic outstanding;                          // Accepted, no response yet

    always_ff @(posedge TCK or posedge RES_DBG)
    begin
        if (RES_DBG)
            outstanding <= 1'b0;
        else if (dm_req_valid && dm_req_ready)
            outstanding <= 1'b1;
        else if (dm_rsp_valid)
            outstanding <= 1'b0;
    end

    // ------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------
    a_req_stable: assert property (@(posedge TCK) disable iff (RES_DBG)
        dm_req_valid && !dm_req_ready |=> dm_req_valid && $stable(dm_req))
        else $error("DM request dropped or changed while waiting for ready");

    // tdo_e follows the state seen at the falling edge
    a_tdo_e_shift: assert property (@(posedge TCK) disable iff (RES_DBG)
        tdo_e |-> (ctl.shift_dr || ctl.shift_ir))
        else $error("TDO enabled outside Shift-IR and Shift-DR");

    a_one_access: assert property (@(posedge TCK) disable iff (RES_DBG)
        outstanding |-> !dm_req_valid)
        else $error("New DM request before the response");

endmodule

bind dtm_jtag_top dtm_jtag_sva u_sva
(
    .TCK          (TCK),
    .RES_DBG      (RES_DBG),
    .ctl          (ctl),
    .tdo_e        (tdo_e),
    .dm_req       (dm_req),
    .dm_req_valid (dm_req_valid),
    .dm_req_ready (dm_req_ready),
    .dm_rsp_valid (dm_rsp_valid)
);

// ==== tests/tb_dtm_jtag.sv ====
// Testbench of the JTAG debug transport module
// Scans IR and DR through the TAP pins, models a small debug module memory
// Random accesses from a fixed xorshift seed, checked against a reference array
`timescale 1ns/100ps
`include "dtm_defs.svh"

module tb_dtm_jtag;
    import dtm_pkg::*;

    localparam logic [31:0] SEED        = 32'h90ed7005;
    localparam int          NUM_SCANS   = 45;
    localparam int          CYCLE_LIMIT = NUM_SCANS * 80 + 500;   // Reset and busy hold in margin

    logic        TCK;
    logic        RES_DBG;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic        tdo_e;
    dmi_req_t    dm_req;
    logic        dm_req_valid;
    logic        dm_req_ready;
    dmi_rsp_t    dm_rsp;
    logic        dm_rsp_valid;
    logic [31:0] stim_rng;
    logic [31:0] model_rng;
    logic [31:0] dm_mem  [128];     // Debug module contents
    logic [31:0] exp_mem [128];     // Reference copy
    logic        hold_ready;        // Stalls the DM model
    int          cycles = 0;

    dtm_jtag_top u_dut
    (
        .TCK          (TCK),
        .RES_DBG      (RES_DBG),
        .tms          (tms),
        .tdi          (tdi),
        .tdo          (tdo),
        .tdo_e        (tdo_e),
        .dm_req       (dm_req),
        .dm_req_valid (dm_req_valid),
        .dm_req_ready (dm_req_ready),
        .dm_rsp       (dm_rsp),
        .dm_rsp_valid (dm_rsp_valid)
    );

    always #4 TCK = ~TCK;               // 8 ns period

    always @(posedge TCK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Verification failed");
            $fatal(1, "Timeout, the test did not finish within %0d TCK cycles", CYCLE_LIMIT);
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [6:0] a);
        return {8'hD0, 1'b0, a, 8'h3C, 1'b1, ~a};
    endfunction

    function automatic logic [40:0] dmi_word(input logic [6:0] a, input logic [31:0] d,
                                             input logic [1:0] op);
        return {a, d, op};              // Op in the LSBs
    endfunction

    // DTMCS layout from the debug spec
    function automatic logic [31:0] dtmcs_word(input logic [1:0] stat);
        return (32'(`DTMCS_IDLE) << 12) | (32'(stat) << 10)
               | (32'(`DTMCS_ABITS) << 4) | 32'(`DTMCS_VERSION);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One TCK cycle, drive on the fall and sample TDO on the rise
    task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(negedge TCK);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge TCK);
        tdo_v = tdo;
    endtask

    task automatic run_idle(input int n);
        logic b;
        repeat (n) tck_step(1'b0, 1'b0, b);
    endtask

    task automatic scan_ir(input logic [4:0] code, output logic [4:0] out);
        logic b;
        tck_step(1'b1, 1'b0, b);        // Select-DR-Scan
        tck_step(1'b1, 1'b0, b);        // Select-IR-Scan
        tck_step(1'b0, 1'b0, b);        // Capture-IR
        tck_step(1'b0, 1'b0, b);        // Into Shift-IR
        for (int i = 0; i < `DTM_IR_WIDTH; i++)
        begin
            tck_step(i == `DTM_IR_WIDTH - 1, code[i], b);
            out[i] = b;
            check_value("tdo_e", tdo_e, 1'b1);     // Driven through Shift-IR
        end
        tck_step(1'b1, 1'b0, b);        // Update-IR
        check_value("tdo_e", tdo_e, 1'b0);
        tck_step(1'b0, 1'b0, b);
    endtask

    task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        dout = '0;
        tck_step(1'b1, 1'b0, b);        // Select-DR-Scan
        tck_step(1'b0, 1'b0, b);        // Capture-DR
        tck_step(1'b0, 1'b0, b);        // Into Shift-DR
        for (int i = 0; i < len; i++)
        begin
            tck_step(i == len - 1, din[i], b);  // Exit1-DR on the last bit
            dout[i] = b;
            check_value("tdo_e", tdo_e, 1'b1);  // Driven through Shift-DR
        end
        tck_step(1'b1, 1'b0, b);        // Update-DR
        check_value("tdo_e", tdo_e, 1'b0);      // Released in Exit1-DR
        tck_step(1'b0, 1'b0, b);        // Back to Run-Test-Idle
    endtask

    task automatic dtmcs_check(input logic clear, input logic [1:0] stat);
        logic [63:0] out;
        scan_dr(32, 64'(clear) << `DTMCS_DMIRESET_BIT, out);
        check_value("dtmcs", out, 64'(dtmcs_word(stat)));
    endtask

    // Scan one DMI word, check what came out, then idle
    task automatic dmi_access(input logic [6:0] a, input logic [31:0] d, input logic [1:0] op,
                              input logic [40:0] exp);
        logic [63:0] out;
        scan_dr(`DMI_WIDTH, 64'(dmi_word(a, d, op)), out);
        check_value("dmi capture", out, 64'(exp));
        run_idle(5);
    endtask

    task automatic wait_response();
        do
            @(posedge TCK);
        while (dm_rsp_valid !== 1'b1);
    endtask

    // ------------------------------------------------------------
    // Debug module model
    // ------------------------------------------------------------
    initial
    begin : dm_model
        logic [6:0] a;
        logic       err;
        dm_req_ready = 1'b0;
        dm_rsp       = '0;
        dm_rsp_valid = 1'b0;
        model_rng    = xorshift(~SEED);
        for (int i = 0; i < 128; i++)
            dm_mem[i] = fill_word(7'(i));
        forever
        begin
            @(posedge TCK);
            if (dm_req_valid === 1'b1)
            begin
                model_rng = xorshift(model_rng);
                repeat (model_rng % 3) @(posedge TCK);     // Ready delay 0 to 2
                @(negedge TCK);
                while (hold_ready)
                    @(negedge TCK);
                dm_req_ready = 1'b1;
                @(posedge TCK);                             // Accepted
                a   = dm_req.addr;
                err = (a >= 7'h7F);
                @(negedge TCK);
                dm_req_ready = 1'b0;
                if (dm_req.op == DMI_WRITE && !err)
                    dm_mem[a] = dm_req.data;
                dm_rsp.err  = err;
                dm_rsp.data = err ? 32'h0 : (dm_req.op == DMI_WRITE) ? ~dm_req.data : dm_mem[a];
                if (model_rng[8])
                    @(negedge TCK);                         // Two-cycle latency
                dm_rsp_valid = 1'b1;
                @(negedge TCK);
                dm_rsp_valid = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin : main
        logic [63:0] out;
        logic [31:0] pat;
        logic [4:0]  ir_out;
        logic [6:0]  addrs [8];
        logic [6:0]  a;
        logic [31:0] d;
        logic [40:0] last;
        logic        b;
        TCK        = 1'b0;
        RES_DBG    = 1'b1;
        tms        = 1'b1;
        tdi        = 1'b0;
        hold_ready = 1'b0;
        stim_rng   = SEED;
        for (int i = 0; i < 128; i++)
            exp_mem[i] = fill_word(7'(i));
        repeat (5) @(posedge TCK);
        @(negedge TCK);
        check_value("tdo", tdo, 1'b1);              // Idle levels in reset
        check_value("tdo_e", tdo_e, 1'b0);
        check_value("dm_req_valid", dm_req_valid, 1'b0);
        RES_DBG = 1'b0;
        tck_step(1'b0, 1'b0, b);        // To Run-Test-Idle

        // IDCODE after reset and after a TMS reset
        scan_dr(32, '0, out);
        check_value("idcode", out, `DTM_IDCODE);
        scan_ir(IR_DTMCS, ir_out);
        check_value("ir capture", ir_out, 5'h01);
        repeat (5) tck_step(1'b1, 1'b0, b);
        tck_step(1'b0, 1'b0, b);
        scan_dr(32, '0, out);
        check_value("idcode after tap reset", out, `DTM_IDCODE);

        // BYPASS and an unknown code, one bit of delay
        for (int k = 0; k < 2; k++)
        begin
            scan_ir((k == 0) ? 5'h1F : 5'h0A, ir_out);
            stim_rng = xorshift(stim_rng);
            pat      = stim_rng;
            scan_dr(32, 64'(pat), out);
            check_value("bypass out", out, {pat[30:0], 1'b0});
        end

        scan_ir(IR_DTMCS, ir_out);
        dtmcs_check(1'b0, STAT_OK);

        // Random writes, then reads of the same words
        scan_ir(IR_DMI, ir_out);
        last = '0;
        for (int i = 0; i < 8; i++)
        begin
            stim_rng = xorshift(stim_rng);
            a        = 7'(stim_rng % 127);
            stim_rng = xorshift(stim_rng);
            d        = stim_rng;
            dmi_access(a, d, DMI_WRITE, last);
            exp_mem[a] = d;
            addrs[i]   = a;
            last       = dmi_word(a, d, DMI_NOP);
        end
        for (int i = 0; i < 8; i++)
        begin
            dmi_access(addrs[i], '0, DMI_READ, last);
            last = dmi_word(addrs[i], exp_mem[addrs[i]], DMI_NOP);
        end

        // Error response at 7F, sticky until dmireset
        dmi_access(7'h7F, '0, DMI_READ, last);
        dmi_access('0, '0, DMI_NOP, dmi_word('0, '0, STAT_FAILED));
        scan_ir(IR_DTMCS, ir_out);
        dtmcs_check(1'b0, STAT_FAILED);
        dtmcs_check(1'b1, STAT_FAILED);     // Captured before the clear
        dtmcs_check(1'b0, STAT_OK);
        scan_ir(IR_DMI, ir_out);
        dmi_access('0, '0, DMI_NOP, dmi_word(7'h7F, '0, DMI_NOP));

        // Rescan while the DM holds ready low
        a          = addrs[3];
        hold_ready = 1'b1;
        dmi_access(a, '0, DMI_READ, dmi_word(7'h7F, '0, DMI_NOP));
        dmi_access('0, '0, DMI_NOP, dmi_word('0, '0, STAT_BUSY));
        hold_ready = 1'b0;
        wait_response();
        scan_ir(IR_DTMCS, ir_out);
        dtmcs_check(1'b0, STAT_BUSY);
        dtmcs_check(1'b1, STAT_BUSY);
        dtmcs_check(1'b0, STAT_OK);
        scan_ir(IR_DMI, ir_out);
        dmi_access('0, '0, DMI_NOP, dmi_word(a, exp_mem[a], DMI_NOP));
        stim_rng = xorshift(stim_rng);
        d        = stim_rng;
        dmi_access(7'h15, d, DMI_WRITE, dmi_word(a, exp_mem[a], DMI_NOP));
        dmi_access(7'h15, '0, DMI_READ, dmi_word(7'h15, d, DMI_NOP));
        dmi_access('0, '0, DMI_NOP, dmi_word(7'h15, d, DMI_NOP));

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/dtm_pkg.sv
verilog/tap_controller.sv
verilog/dtm_data_regs.sv
verilog/dmi_bus_master.sv
verilog/dtm_jtag_top.sv
tests/dtm_jtag_sva.sv
tests/tb_dtm_jtag.sv

// ==== Bender.yml ====
package:
  name: dtm_jtag

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dtm_pkg.sv
      - verilog/tap_controller.sv
      - verilog/dtm_data_regs.sv
      - verilog/dmi_bus_master.sv
      - verilog/dtm_jtag_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/dtm_jtag_sva.sv
      - tests/tb_dtm_jtag.sv
